// ==== verilog/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  // Architectural register file geometry
  localparam int NUM_REGS     = 32;
  localparam int XLEN_DEFAULT = 32;

  typedef logic [4:0] reg_addr_t;

  localparam reg_addr_t REG_X0 = reg_addr_t'(0);

  // OP-IMM group first, register-register group last
  typedef enum logic [4:0] {
    OP_LUI   = 5'd0,
    OP_AUIPC = 5'd1,
    OP_ADDI  = 5'd2,
    OP_SLTI  = 5'd3,
    OP_SLTIU = 5'd4,
    OP_XORI  = 5'd5,
    OP_ORI   = 5'd6,
    OP_ANDI  = 5'd7,
    OP_SLLI  = 5'd8,
    OP_SRLI  = 5'd9,
    OP_SRAI  = 5'd10,
    OP_ADD   = 5'd11,
    OP_SUB   = 5'd12,
    OP_SLL   = 5'd13,
    OP_SLT   = 5'd14,
    OP_SLTU  = 5'd15,
    OP_XOR   = 5'd16,
    OP_SRL   = 5'd17,
    OP_SRA   = 5'd18,
    OP_OR    = 5'd19,
    OP_AND   = 5'd20
  } alu_op_e;

  // True for the OP group, where rs2 is a real source
  function automatic logic uses_rs2(alu_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
  endfunction

endpackage

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`default_nettype none

module rv_regfile
  import rv_exec_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire logic            in_clk,
  input  wire logic            in_rst,
  input  wire reg_addr_t       raddr1_i,
  input  wire reg_addr_t       raddr2_i,
  output logic [XLEN-1:0]      rdata1_o,
  output logic [XLEN-1:0]      rdata2_o,
  input  wire logic            we_i,
  input  wire reg_addr_t       waddr_i,
  input  wire logic [XLEN-1:0] wdata_i
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != REG_X0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 first, then same-cycle write forwarding
  always_comb begin
    if (raddr1_i == REG_X0) begin
      rdata1_o = '0;
    end else if (we_i && raddr1_i == waddr_i) begin
      rdata1_o = wdata_i;
    end else begin
      rdata1_o = regs[raddr1_i];
    end
  end

  always_comb begin
    if (raddr2_i == REG_X0) begin
      rdata2_o = '0;
    end else if (we_i && raddr2_i == waddr_i) begin
      rdata2_o = wdata_i;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

  // Writeback must filter x0 results itself
  a_no_x0_write: assert property (
    @(posedge in_clk) disable iff (!in_rst)
    we_i |-> waddr_i != REG_X0
  );

endmodule

`default_nettype wire

// ==== verilog/rv_issue.sv ====
`default_nettype none

module rv_issue
  import rv_exec_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire logic            in_clk,
  input  wire logic            in_rst,
  input  wire logic            instr_valid_i,
  output logic                 instr_ready_o,
  input  wire alu_op_e         op_i,
  input  wire reg_addr_t       rd_i,
  input  wire reg_addr_t       rs1_i,
  input  wire reg_addr_t       rs2_i,
  input  wire logic [XLEN-1:0] imm_i,
  input  wire logic [XLEN-1:0] pc_i,
  output reg_addr_t            raddr1_o,
  output reg_addr_t            raddr2_o,
  input  wire logic [XLEN-1:0] rdata1_i,
  input  wire logic [XLEN-1:0] rdata2_i,
  input  wire logic            wb_done_i,
  input  wire reg_addr_t       wb_rd_i,
  output logic                 iss_valid_o,
  input  wire logic            alu_ready_i,
  output alu_op_e              iss_op_o,
  output reg_addr_t            iss_rd_o,
  output logic [XLEN-1:0]      iss_a_o,
  output logic [XLEN-1:0]      iss_b_o,
  output logic [XLEN-1:0]      iss_imm_o,
  output logic [XLEN-1:0]      iss_pc_o
);

  logic [NUM_REGS-1:0] busy;
  logic [NUM_REGS-1:0] busy_nxt;
  logic [NUM_REGS-1:0] release_mask;
  logic [NUM_REGS-1:0] busy_eff;
  logic                hazard;
  logic                slot_free;
  logic                accept;

  assign raddr1_o = rs1_i;
  assign raddr2_o = rs2_i;

  // A retiring result is already visible through the regfile bypass
  always_comb begin
    release_mask = '0;
    if (wb_done_i) begin
      release_mask[wb_rd_i] = 1'b1;
    end
  end

  assign busy_eff = busy & ~release_mask;

  // rd is checked too so an older write cannot clear a newer busy bit
  assign hazard = busy_eff[rs1_i] |
                  (uses_rs2(op_i) & busy_eff[rs2_i]) |
                  busy_eff[rd_i];

  assign slot_free     = !iss_valid_o || alu_ready_i;
  assign instr_ready_o = slot_free && !hazard;
  assign accept        = instr_valid_i && instr_ready_o;

  always_comb begin
    busy_nxt = busy & ~release_mask;
    if (accept && rd_i != REG_X0) begin
      busy_nxt[rd_i] = 1'b1;
    end
  end

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      busy        <= '0;
      iss_valid_o <= 1'b0;
    end else begin
      busy <= busy_nxt;
      if (accept) begin
        iss_valid_o <= 1'b1;
      end else if (alu_ready_i) begin
        iss_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (accept) begin
      iss_op_o  <= op_i;
      iss_rd_o  <= rd_i;
      iss_a_o   <= rdata1_i;
      iss_b_o   <= rdata2_i;
      iss_imm_o <= imm_i;
      iss_pc_o  <= pc_i;
    end
  end

  // Upstream must hold a stalled instruction
  a_instr_stable: assert property (
    @(posedge in_clk) disable iff (!in_rst)
    instr_valid_i && !instr_ready_o |=>
      $stable(op_i) && $stable(rd_i) && $stable(rs1_i) &&
      $stable(rs2_i) && $stable(imm_i) && $stable(pc_i)
  );

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`default_nettype none

module rv_alu
  import rv_exec_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire logic            in_clk,
  input  wire logic            in_rst,
  input  wire logic            iss_valid_i,
  output logic                 alu_ready_o,
  input  wire alu_op_e         iss_op_i,
  input  wire reg_addr_t       iss_rd_i,
  input  wire logic [XLEN-1:0] iss_a_i,
  input  wire logic [XLEN-1:0] iss_b_i,
  input  wire logic [XLEN-1:0] iss_imm_i,
  input  wire logic [XLEN-1:0] iss_pc_i,
  output logic                 alu_valid_o,
  input  wire logic            wb_ready_i,
  output reg_addr_t            alu_rd_o,
  output logic [XLEN-1:0]      alu_result_o
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] opnd_b;
  logic [SHW-1:0]  shamt;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] result;
  logic            load;

  // Register operand only for the OP group
  assign opnd_b = uses_rs2(iss_op_i) ? iss_b_i : iss_imm_i;
  assign shamt  = opnd_b[SHW-1:0];
  assign lt_s   = $signed(iss_a_i) < $signed(opnd_b);
  assign lt_u   = iss_a_i < opnd_b;

  always_comb begin
    case (iss_op_i)
      OP_LUI:           result = iss_imm_i;
      OP_AUIPC:         result = iss_pc_i + iss_imm_i;
      OP_ADDI, OP_ADD:  result = iss_a_i + opnd_b;
      OP_SUB:           result = iss_a_i - opnd_b;
      OP_SLTI, OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
      OP_SLTIU, OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
      OP_XORI, OP_XOR:  result = iss_a_i ^ opnd_b;
      OP_ORI, OP_OR:    result = iss_a_i | opnd_b;
      OP_ANDI, OP_AND:  result = iss_a_i & opnd_b;
      OP_SLLI, OP_SLL:  result = iss_a_i << shamt;
      OP_SRLI, OP_SRL:  result = iss_a_i >> shamt;
      // Arithmetic shift keeps the sign
      OP_SRAI, OP_SRA:  result = $unsigned($signed(iss_a_i) >>> shamt);
      default:          result = '0;
    endcase
  end

  assign alu_ready_o = !alu_valid_o || wb_ready_i;
  assign load        = iss_valid_i && alu_ready_o;

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      alu_valid_o <= 1'b0;
    end else if (load) begin
      alu_valid_o <= 1'b1;
    end else if (wb_ready_i) begin
      alu_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (load) begin
      alu_rd_o     <= iss_rd_i;
      alu_result_o <= result;
    end
  end

  // Decoder upstream only sends the kept operations
  a_legal_op: assert property (
    @(posedge in_clk) disable iff (!in_rst)
    iss_valid_i |-> !$isunknown(iss_op_i) && iss_op_i inside {[OP_LUI:OP_AND]}
  );

endmodule

`default_nettype wire

// ==== verilog/rv_writeback.sv ====
`default_nettype none

module rv_writeback
  import rv_exec_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire logic            in_clk,
  input  wire logic            in_rst,
  input  wire logic            alu_valid_i,
  output logic                 wb_ready_o,
  input  wire reg_addr_t       alu_rd_i,
  input  wire logic [XLEN-1:0] alu_result_i,
  output logic                 res_valid_o,
  input  wire logic            res_ready_i,
  output reg_addr_t            res_rd_o,
  output logic [XLEN-1:0]      res_data_o,
  output logic                 we_o,
  output reg_addr_t            waddr_o,
  output logic [XLEN-1:0]      wdata_o,
  output logic                 wb_done_o,
  output reg_addr_t            wb_rd_o
);

  logic res_hs;
  logic load;

  assign res_hs     = res_valid_o && res_ready_i;
  assign wb_ready_o = !res_valid_o || res_ready_i;
  assign load       = alu_valid_i && wb_ready_o;

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      res_valid_o <= 1'b0;
    end else if (load) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (load) begin
      res_rd_o   <= alu_rd_i;
      res_data_o <= alu_result_i;
    end
  end

  // Commit to the regfile as the result leaves
  // A result for x0 is only reported
  assign we_o    = res_hs && res_rd_o != REG_X0;
  assign waddr_o = res_rd_o;
  assign wdata_o = res_data_o;

  // Scoreboard release
  assign wb_done_o = res_hs;
  assign wb_rd_o   = res_rd_o;

  a_res_stable: assert property (
    @(posedge in_clk) disable iff (!in_rst)
    res_valid_o && !res_ready_i |=>
      res_valid_o && $stable(res_rd_o) && $stable(res_data_o)
  );

endmodule

`default_nettype wire

// ==== verilog/rv_exec_top.sv ====
`default_nettype none

module rv_exec_top
  import rv_exec_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire logic            in_clk,
  input  wire logic            in_rst,
  input  wire logic            instr_valid_i,
  output logic                 instr_ready_o,
  input  wire alu_op_e         op_i,
  input  wire reg_addr_t       rd_i,
  input  wire reg_addr_t       rs1_i,
  input  wire reg_addr_t       rs2_i,
  input  wire logic [XLEN-1:0] imm_i,
  input  wire logic [XLEN-1:0] pc_i,
  output logic                 res_valid_o,
  input  wire logic            res_ready_i,
  output reg_addr_t            res_rd_o,
  output logic [XLEN-1:0]      res_data_o
);

  // Regfile ports
  reg_addr_t       raddr1;
  reg_addr_t       raddr2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic            we;
  reg_addr_t       waddr;
  logic [XLEN-1:0] wdata;

  // Issue to ALU
  logic            iss_valid;
  logic            alu_ready;
  alu_op_e         iss_op;
  reg_addr_t       iss_rd;
  logic [XLEN-1:0] iss_a;
  logic [XLEN-1:0] iss_b;
  logic [XLEN-1:0] iss_imm;
  logic [XLEN-1:0] iss_pc;

  // ALU to writeback
  logic            alu_valid;
  logic            wb_ready;
  reg_addr_t       alu_rd;
  logic [XLEN-1:0] alu_result;

  logic            wb_done;
  reg_addr_t       wb_rd;

  rv_regfile #(.XLEN(XLEN)) u_regfile (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (we),
    .waddr_i  (waddr),
    .wdata_i  (wdata)
  );

  rv_issue #(.XLEN(XLEN)) u_issue (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .pc_i          (pc_i),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .wb_done_i     (wb_done),
    .wb_rd_i       (wb_rd),
    .iss_valid_o   (iss_valid),
    .alu_ready_i   (alu_ready),
    .iss_op_o      (iss_op),
    .iss_rd_o      (iss_rd),
    .iss_a_o       (iss_a),
    .iss_b_o       (iss_b),
    .iss_imm_o     (iss_imm),
    .iss_pc_o      (iss_pc)
  );

  rv_alu #(.XLEN(XLEN)) u_alu (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .iss_valid_i  (iss_valid),
    .alu_ready_o  (alu_ready),
    .iss_op_i     (iss_op),
    .iss_rd_i     (iss_rd),
    .iss_a_i      (iss_a),
    .iss_b_i      (iss_b),
    .iss_imm_i    (iss_imm),
    .iss_pc_i     (iss_pc),
    .alu_valid_o  (alu_valid),
    .wb_ready_i   (wb_ready),
    .alu_rd_o     (alu_rd),
    .alu_result_o (alu_result)
  );

  rv_writeback #(.XLEN(XLEN)) u_writeback (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .alu_valid_i  (alu_valid),
    .wb_ready_o   (wb_ready),
    .alu_rd_i     (alu_rd),
    .alu_result_i (alu_result),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_rd_o     (res_rd_o),
    .res_data_o   (res_data_o),
    .we_o         (we),
    .waddr_o      (waddr),
    .wdata_o      (wdata),
    .wb_done_o    (wb_done),
    .wb_rd_o      (wb_rd)
  );

endmodule

`default_nettype wire

// ==== sim/rv_exec_tb.sv ====
`default_nettype none

module rv_exec_tb
  import rv_exec_pkg::*;
;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int N_TABLE    = 29;
  localparam int N_READBACK = 7;
  localparam int N_ENTRIES  = N_TABLE + N_READBACK;

  typedef struct packed {
    alu_op_e     op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] exp;
  } entry_t;

  logic        in_clk;
  logic        in_rst;
  logic        instr_valid_i;
  logic        instr_ready_o;
  alu_op_e     op_i;
  reg_addr_t   rd_i;
  reg_addr_t   rs1_i;
  reg_addr_t   rs2_i;
  logic [31:0] imm_i;
  logic [31:0] pc_i;
  logic        res_valid_o;
  logic        res_ready_i;
  reg_addr_t   res_rd_o;
  logic [31:0] res_data_o;

  entry_t      tbl [N_ENTRIES];
  logic [31:0] ref_regs [NUM_REGS];
  int          n_loaded = 0;
  int          errors = 0;
  int          cyc = 0;
  int          first_hs_cyc = 0;
  int          seed = 32'h6d58_5bdd;
  logic        stall_en = 1'b0;

  rv_exec_top #(.XLEN(32)) dut0 (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .pc_i          (pc_i),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o)
  );

  initial begin
    in_clk = 1'b0;
    forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
  end

  always @(posedge in_clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input alu_op_e op, input int rd, input int rs1, input int rs2,
                           input logic [31:0] imm, input logic [31:0] pc,
                           input logic [31:0] exp);
    tbl[n_loaded].op  = op;
    tbl[n_loaded].rd  = reg_addr_t'(rd);
    tbl[n_loaded].rs1 = reg_addr_t'(rs1);
    tbl[n_loaded].rs2 = reg_addr_t'(rs2);
    tbl[n_loaded].imm = imm;
    tbl[n_loaded].pc  = pc;
    tbl[n_loaded].exp = exp;
    n_loaded++;
  endtask

  task automatic load_table();
    add_entry(OP_LUI,   1, 0, 0, 32'h1234_5000, 32'h0000_0000, 32'h1234_5000);
    add_entry(OP_AUIPC, 2, 0, 0, 32'h0000_1000, 32'h0000_0400, 32'h0000_1400);
    add_entry(OP_ADDI,  3, 1, 0, 32'hffff_ffff, 32'h0000_0408, 32'h1234_4fff);
    add_entry(OP_XORI,  4, 1, 0, 32'hffff_f800, 32'h0000_040c, 32'hedcb_a800);
    add_entry(OP_ORI,   5, 2, 0, 32'hffff_ff00, 32'h0000_0410, 32'hffff_ff00);
    add_entry(OP_ANDI,  6, 4, 0, 32'hffff_f0ff, 32'h0000_0414, 32'hedcb_a000);
    // Sign bits differ between x4 and x1
    add_entry(OP_SLT,   7, 4, 1, 32'h0000_0000, 32'h0000_0418, 32'h0000_0001);
    add_entry(OP_SLTU,  7, 4, 1, 32'h0000_0000, 32'h0000_041c, 32'h0000_0000);
    add_entry(OP_SLTI,  7, 4, 0, 32'h0000_0001, 32'h0000_0420, 32'h0000_0001);
    add_entry(OP_SLTIU, 7, 4, 0, 32'h0000_0001, 32'h0000_0424, 32'h0000_0000);
    add_entry(OP_SRAI,  6, 4, 0, 32'h0000_0004, 32'h0000_0428, 32'hfedc_ba80);
    add_entry(OP_SRLI,  6, 4, 0, 32'h0000_0004, 32'h0000_042c, 32'h0edc_ba80);
    // Shift amount 40 uses only its low 5 bits (8)
    add_entry(OP_ADDI,  5, 0, 0, 32'h0000_0028, 32'h0000_0430, 32'h0000_0028);
    add_entry(OP_SRA,   6, 4, 5, 32'h0000_0000, 32'h0000_0434, 32'hffed_cba8);
    add_entry(OP_SRL,   6, 4, 5, 32'h0000_0000, 32'h0000_0438, 32'h00ed_cba8);
    add_entry(OP_SLL,   6, 1, 5, 32'h0000_0000, 32'h0000_043c, 32'h3450_0000);
    add_entry(OP_SLLI,  6, 1, 0, 32'h0000_0004, 32'h0000_0440, 32'h2345_0000);
    add_entry(OP_ADD,   6, 1, 2, 32'h0000_0000, 32'h0000_0444, 32'h1234_6400);
    add_entry(OP_SUB,   6, 2, 1, 32'h0000_0000, 32'h0000_0448, 32'hedcb_c400);
    add_entry(OP_XOR,   6, 1, 4, 32'h0000_0000, 32'h0000_044c, 32'hffff_f800);
    add_entry(OP_OR,    6, 2, 3, 32'h0000_0000, 32'h0000_0450, 32'h1234_5fff);
    add_entry(OP_AND,   6, 4, 3, 32'h0000_0000, 32'h0000_0454, 32'h0000_0800);
    // Dependent chain through x7
    add_entry(OP_ADDI,  7, 0, 0, 32'h0000_0005, 32'h0000_0458, 32'h0000_0005);
    add_entry(OP_ADDI,  7, 7, 0, 32'h0000_0007, 32'h0000_045c, 32'h0000_000c);
    add_entry(OP_SLLI,  7, 7, 0, 32'h0000_0002, 32'h0000_0460, 32'h0000_0030);
    add_entry(OP_ADD,   7, 7, 7, 32'h0000_0000, 32'h0000_0464, 32'h0000_0060);
    add_entry(OP_XORI,  7, 7, 0, 32'hffff_ffff, 32'h0000_0468, 32'hffff_ff9f);
    // x0 as destination still reports and x0 as source reads zero
    add_entry(OP_ADDI,  0, 1, 0, 32'h0000_0000, 32'h0000_046c, 32'h1234_5000);
    add_entry(OP_ORI,   6, 0, 0, 32'h0000_007f, 32'h0000_0470, 32'h0000_007f);
    // Read the final register state back through x0 results
    for (int r = 0; r < NUM_REGS; r++) begin
      ref_regs[r] = 32'h0;
    end
    for (int i = 0; i < N_TABLE; i++) begin
      if (tbl[i].rd != REG_X0) begin
        ref_regs[tbl[i].rd] = tbl[i].exp;
      end
    end
    for (int r = 1; r <= N_READBACK; r++) begin
      add_entry(OP_ADD, 0, r, 0, 32'h0, 32'h0000_0500, ref_regs[r]);
    end
  endtask

  task automatic apply_instructions();
    for (int i = 0; i < N_ENTRIES; i++) begin
      instr_valid_i = 1'b1;
      op_i          = tbl[i].op;
      rd_i          = tbl[i].rd;
      rs1_i         = tbl[i].rs1;
      rs2_i         = tbl[i].rs2;
      imm_i         = tbl[i].imm;
      pc_i          = tbl[i].pc;
      @(posedge in_clk);
      while (!instr_ready_o) begin
        @(posedge in_clk);
      end
      if (i == 0) begin
        first_hs_cyc = cyc;
      end
      #1;
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic collect_results();
    int n;
    n = 0;
    while (n < N_ENTRIES) begin
      @(posedge in_clk);
      if (res_valid_o && res_ready_i) begin
        check_value($sformatf("entry %0d rd", n), 32'(res_rd_o), 32'(tbl[n].rd));
        check_value($sformatf("entry %0d data", n), res_data_o, tbl[n].exp);
        if (n == 0) begin
          check_value("latency of first result", 32'(cyc - first_hs_cyc), 32'd3);
          stall_en = 1'b1;
        end
        n++;
      end
    end
  endtask

  // Result back-pressure
  initial begin
    res_ready_i = 1'b1;
    forever begin
      @(posedge in_clk);
      #1;
      res_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  initial begin
    in_rst        = 1'b0;
    instr_valid_i = 1'b0;
    op_i          = OP_ADDI;
    rd_i          = REG_X0;
    rs1_i         = REG_X0;
    rs2_i         = REG_X0;
    imm_i         = 32'h0;
    pc_i          = 32'h0;
    load_table();
    repeat (RST_CYCLES) @(posedge in_clk);
    #1 in_rst = 1'b1;
    @(posedge in_clk);
    check_value("res_valid_o after reset", 32'(res_valid_o), 32'd0);
    check_value("instr_ready_o after reset", 32'(instr_ready_o), 32'd1);
    #1;
    fork
      apply_instructions();
      collect_results();
    join
    stall_en = 1'b0;
    // No extra results
    repeat (10) begin
      @(posedge in_clk);
      check_value("res_valid_o after last result", 32'(res_valid_o), 32'd0);
    end
    $display("Results checked: %0d, errors: %0d", N_ENTRIES, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #((RST_CYCLES + 40 * N_ENTRIES) * CLK_PERIOD);
    $display("Run timed out after %0d cycles with results still missing",
             RST_CYCLES + 40 * N_ENTRIES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/rv_exec_pkg.sv
verilog/rv_regfile.sv
verilog/rv_issue.sv
verilog/rv_alu.sv
verilog/rv_writeback.sv
verilog/rv_exec_top.sv
sim/rv_exec_tb.sv
